// ==== list.f ====
src/periphPkg.sv
src/periphReqIn.sv
src/aclintTimer.sv
src/sysCtrl.sv
src/periphRspOut.sv
src/periphTop.sv
test/periphChecker.sv
test/periphTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f list.f --top-module periphTb -o periphSim

output="$(./obj_dir/periphSim)"
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
    exit 0
else
    exit 1
fi

// ==== test/periphTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module periphTb;

    import periphPkg::*;

    localparam int NUM_ENTRIES  = 36;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_HOLD     = 15;
    localparam int WATCHDOG_NS  = (NUM_ENTRIES * (MAX_HOLD + 4) + RESET_CYCLES) * CLK_PERIOD;

    localparam logic       RD        = 1'b0;
    localparam logic       WR        = 1'b1;
    localparam logic [3:0] RAND_HOLD = 4'hF;
    localparam logic [7:0] LFSR_SEED = 8'd53;

    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [3:0]  mask;
        logic [31:0] data;
        logic [3:0]  hold;
    } stimEntry;

    logic        clk;
    logic        rst;
    logic        reqValid;
    periphReq    req;
    logic        reqReady;
    logic        rspValid;
    periphRsp    rsp;
    logic        rspReady;
    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        timerIrq;
    logic        reboot;
    logic        powerOff;
    logic        testDone;
    int          errorCount;
    stimEntry    stim [NUM_ENTRIES];
    int          loadIndex;
    logic [7:0]  lfsr;

    periphTop periphTop_i (
        .clk      (clk),
        .rst      (rst),
        .reqValid (reqValid),
        .req      (req),
        .reqReady (reqReady),
        .rspValid (rspValid),
        .rsp      (rsp),
        .rspReady (rspReady),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .timerIrq (timerIrq),
        .reboot   (reboot),
        .powerOff (powerOff)
    );

    periphChecker #(
        .NUM_REQ (NUM_ENTRIES)
    ) periphChecker_i (
        .clk        (clk),
        .rst        (rst),
        .reqValid   (reqValid),
        .req        (req),
        .reqReady   (reqReady),
        .rspValid   (rspValid),
        .rsp        (rsp),
        .rspReady   (rspReady),
        .mtime      (mtime),
        .mtimecmp   (mtimecmp),
        .timerIrq   (timerIrq),
        .reboot     (reboot),
        .powerOff   (powerOff),
        .testDone   (testDone),
        .errorCount (errorCount)
    );

    // Taps for x^8 + x^6 + x^5 + x^4 + 1.
    function automatic logic [7:0] stepLfsr(input logic [7:0] state);
        return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
    endfunction

    task automatic addEntry(input logic write, input logic [31:0] addr, input logic [3:0] mask,
                            input logic [31:0] data, input logic [3:0] hold);
        stim[loadIndex] = '{write, addr, mask, data, hold};
        loadIndex++;
    endtask

    task automatic loadStimulus();
        // Reset values and masked mtimecmp writes.
        addEntry(RD, MTIMECMP_ADDR, 4'hF, 32'd0, 4'd0);
        addEntry(RD, MTIMECMP_ADDR + 32'd4, 4'hF, 32'd0, 4'd0);
        addEntry(WR, MTIMECMP_ADDR, 4'h5, 32'h11223344, 4'd0);
        addEntry(RD, MTIMECMP_ADDR, 4'hF, 32'd0, 4'd1);
        addEntry(WR, MTIMECMP_ADDR + 32'd4, 4'h8, 32'hAABBCCDD, 4'd2);
        addEntry(RD, MTIMECMP_ADDR + 32'd4, 4'hF, 32'd0, 4'd0);
        // mtime writes and read-back.
        addEntry(WR, MTIME_ADDR + 32'd4, 4'hF, 32'd0, 4'd0);
        addEntry(WR, MTIME_ADDR, 4'h2, 32'h0000AB00, 4'd0);
        addEntry(RD, MTIME_ADDR, 4'hF, 32'd0, 4'd0);
        addEntry(WR, MTIME_ADDR, 4'hF, 32'h00001000, 4'd0);
        addEntry(RD, MTIME_ADDR, 4'hF, 32'd0, 4'd3);
        addEntry(RD, MTIME_ADDR + 32'd4, 4'hF, 32'd0, 4'd0);
        // Compare value a little ahead of mtime, then wait for the interrupt.
        addEntry(WR, MTIMECMP_ADDR, 4'hF, 32'h00001040, 4'd0);
        addEntry(WR, MTIMECMP_ADDR + 32'd4, 4'hF, 32'd0, 4'd0);
        for (int i = 0; i < 5; i++) begin
            addEntry(RD, MTIME_ADDR, 4'hF, 32'd0, 4'd12);
        end
        addEntry(WR, MTIMECMP_ADDR + 32'd4, 4'hF, 32'd1, 4'd0);
        addEntry(RD, MTIMECMP_ADDR + 32'd4, 4'hF, 32'd0, 4'd0);
        // System controller and unmapped space.
        addEntry(WR, SYSCON_ADDR, 4'h1, 32'h00000077, 4'd0);
        addEntry(WR, SYSCON_ADDR, 4'hF, 32'h00000055, 4'd1);
        addEntry(WR, SYSCON_ADDR, 4'hE, 32'h00000077, 4'd0);
        addEntry(WR, SYSCON_ADDR, 4'hF, 32'h00000012, 4'd0);
        addEntry(RD, SYSCON_ADDR, 4'hF, 32'd0, 4'd0);
        addEntry(RD, 32'h10000000, 4'hF, 32'd0, 4'd0);
        addEntry(WR, 32'h0200BFF0, 4'hF, 32'hDEADBEEF, 4'd0);
        // Random stalls on the response side.
        addEntry(RD, MTIME_ADDR, 4'hF, 32'd0, RAND_HOLD);
        addEntry(WR, MTIMECMP_ADDR, 4'hF, 32'h00000020, RAND_HOLD);
        addEntry(RD, MTIMECMP_ADDR, 4'hF, 32'd0, RAND_HOLD);
        addEntry(RD, 32'h00000000, 4'hF, 32'd0, RAND_HOLD);
        addEntry(WR, MTIME_ADDR + 32'd4, 4'h3, 32'h00000005, RAND_HOLD);
        addEntry(RD, MTIME_ADDR + 32'd4, 4'hF, 32'd0, RAND_HOLD);
        addEntry(WR, SYSCON_ADDR, 4'hF, 32'h00000099, RAND_HOLD);
        addEntry(RD, MTIMECMP_ADDR + 32'd4, 4'hF, 32'd0, RAND_HOLD);
    endtask

    // Holds each request until the edge that takes it.
    task automatic driveRequests();
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            reqValid     = 1'b1;
            req.write    = stim[i].write;
            req.wordAddr = stim[i].addr[31:2];
            req.wmask    = stim[i].mask;
            req.wdata    = stim[i].data;
            do @(negedge clk); while (!reqReady);
            @(posedge clk);
            #1;
        end
        reqValid = 1'b0;
        req      = '0;
    endtask

    task automatic driveResponses();
        logic [3:0] holdCycles;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            holdCycles = stim[i].hold;
            if (holdCycles == RAND_HOLD) begin
                holdCycles = 4'd0;
                for (int b = 0; b < 3; b++) begin
                    lfsr          = stepLfsr(lfsr);
                    holdCycles[b] = lfsr[0];
                end
            end
            if (holdCycles != 4'd0) begin
                rspReady = 1'b0;
                repeat (holdCycles) @(posedge clk);
                #1;
            end
            rspReady = 1'b1;
            do @(negedge clk); while (!rspValid);
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not end within %0d ns", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        reqValid  = 1'b0;
        req       = '0;
        rspReady  = 1'b0;
        testDone  = 1'b0;
        lfsr      = LFSR_SEED;
        loadIndex = 0;
        loadStimulus();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        fork
            driveRequests();
            driveResponses();
        join
        repeat (4) @(posedge clk);
        testDone = 1'b1;
        repeat (2) @(posedge clk);
        $display("Errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/periphChecker.sv ====
`timescale 1ns/10ps
`default_nettype none

module periphChecker #(
    parameter int NUM_REQ = 1
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 reqValid,
    input  periphPkg::periphReq req,
    input  wire                 reqReady,
    input  wire                 rspValid,
    input  periphPkg::periphRsp rsp,
    input  wire                 rspReady,
    input  wire [63:0]          mtime,
    input  wire [63:0]          mtimecmp,
    input  wire                 timerIrq,
    input  wire                 reboot,
    input  wire                 powerOff,
    input  wire                 testDone,
    output int                  errorCount
);

    import periphPkg::*;

    periphReq    stageReq;
    logic        modelFull;
    logic        modelRspValid;
    logic [63:0] modelMtime;
    logic [63:0] modelCmp;
    logic        modelIrq;
    logic        modelReboot;
    logic        modelPowerOff;
    logic        prevIrq;
    logic        doneSeen;
    periphRsp    expQ[$];
    int          acceptCount;
    int          takeCount;
    int          rebootCount;
    int          powerOffCount;
    int          irqRises;
    int          irqFalls;

    function automatic logic [31:0] byteMerge(
        input logic [31:0] oldWord,
        input logic [31:0] data,
        input logic [3:0]  mask
    );
        logic [31:0] keep;
        keep = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        return (oldWord & ~keep) | (data & keep);
    endfunction

    task automatic compareValue(input string name, input logic [63:0] got,
                                input logic [63:0] expected);
        if (got !== expected) begin
            $display("Fail %s: expected %0h, got %0h at %0t", name, expected, got, $time);
            errorCount++;
        end
    endtask

    // Values sampled at the falling edge belong to the next rising edge.
    always @(negedge clk) begin
        logic        issueNow;
        logic        modelReady;
        logic        accept;
        logic        isTimer;
        logic [31:0] addr;
        logic [31:0] curWord;
        logic [63:0] nextMtime;
        periphRsp    expRsp;
        if (rst) begin
            modelFull     = 1'b0;
            modelRspValid = 1'b0;
            modelMtime    = 64'd0;
            modelCmp      = '1;
            modelIrq      = 1'b0;
            modelReboot   = 1'b0;
            modelPowerOff = 1'b0;
            prevIrq       = 1'b0;
            doneSeen      = 1'b0;
            errorCount    = 0;
            acceptCount   = 0;
            takeCount     = 0;
            rebootCount   = 0;
            powerOffCount = 0;
            irqRises      = 0;
            irqFalls      = 0;
            expQ.delete();
        end else begin
            issueNow   = modelFull && (!modelRspValid || rspReady);
            modelReady = !modelFull || issueNow;
            accept     = reqValid && modelReady;

            compareValue("mtime", mtime, modelMtime);
            compareValue("mtimecmp", mtimecmp, modelCmp);
            compareValue("timerIrq", 64'(timerIrq), 64'(modelIrq));
            compareValue("reboot", 64'(reboot), 64'(modelReboot));
            compareValue("powerOff", 64'(powerOff), 64'(modelPowerOff));
            compareValue("rspValid", 64'(rspValid), 64'(modelRspValid));
            compareValue("reqReady", 64'(reqReady), 64'(modelReady));

            if (rspValid && rspReady) begin
                if (expQ.size() == 0) begin
                    $display("A response was taken with no request pending at %0t", $time);
                    errorCount++;
                end else begin
                    expRsp = expQ.pop_front();
                    compareValue("rsp.rdata", 64'(rsp.rdata), 64'(expRsp.rdata));
                    compareValue("rsp.err", 64'(rsp.err), 64'(expRsp.err));
                end
                takeCount++;
            end

            if (reboot) rebootCount++;
            if (powerOff) powerOffCount++;
            if (timerIrq && !prevIrq) irqRises++;
            if (!timerIrq && prevIrq) irqFalls++;
            prevIrq = timerIrq;

            // Register model from the values before the edge.
            nextMtime     = modelMtime + 64'd1;
            modelIrq      = (modelMtime >= modelCmp);
            modelReboot   = 1'b0;
            modelPowerOff = 1'b0;
            if (issueNow) begin
                addr    = {stageReq.wordAddr, 2'b00};
                isTimer = 1'b1;
                case (addr)
                    MTIME_ADDR:            curWord = modelMtime[31:0];
                    MTIME_ADDR + 32'd4:    curWord = modelMtime[63:32];
                    MTIMECMP_ADDR:         curWord = modelCmp[31:0];
                    MTIMECMP_ADDR + 32'd4: curWord = modelCmp[63:32];
                    default: begin
                        curWord = 32'd0;
                        isTimer = 1'b0;
                    end
                endcase
                expRsp.err   = !isTimer && (addr != SYSCON_ADDR);
                expRsp.rdata = stageReq.write ? 32'd0 : curWord;
                expQ.push_back(expRsp);
                if (stageReq.write) begin
                    case (addr)
                        MTIME_ADDR: nextMtime[31:0] =
                            byteMerge(nextMtime[31:0], stageReq.wdata, stageReq.wmask);
                        MTIME_ADDR + 32'd4: nextMtime[63:32] =
                            byteMerge(nextMtime[63:32], stageReq.wdata, stageReq.wmask);
                        MTIMECMP_ADDR: modelCmp[31:0] =
                            byteMerge(modelCmp[31:0], stageReq.wdata, stageReq.wmask);
                        MTIMECMP_ADDR + 32'd4: modelCmp[63:32] =
                            byteMerge(modelCmp[63:32], stageReq.wdata, stageReq.wmask);
                        default: begin
                        end
                    endcase
                    if (addr == SYSCON_ADDR && stageReq.wmask[0]) begin
                        modelReboot   = (stageReq.wdata[7:0] == REBOOT_CODE);
                        modelPowerOff = (stageReq.wdata[7:0] == POWEROFF_CODE);
                    end
                end
            end
            modelMtime = nextMtime;

            if (issueNow) begin
                modelRspValid = 1'b1;
            end else if (rspReady) begin
                modelRspValid = 1'b0;
            end
            if (accept) begin
                modelFull = 1'b1;
                stageReq  = req;
                acceptCount++;
            end else if (issueNow) begin
                modelFull = 1'b0;
            end

            if (testDone && !doneSeen) begin
                doneSeen = 1'b1;
                if (expQ.size() != 0 || acceptCount != NUM_REQ || takeCount != NUM_REQ) begin
                    $display("Requests lost or duplicated: %0d sent, %0d accepted, %0d answered",
                             NUM_REQ, acceptCount, takeCount);
                    errorCount++;
                end
                if (rebootCount != 1 || powerOffCount != 1) begin
                    $display("Expected one reboot and one power-off pulse, saw %0d and %0d",
                             rebootCount, powerOffCount);
                    errorCount++;
                end
                if (irqRises == 0 || irqFalls == 0) begin
                    $display("The timer interrupt never both rose and fell");
                    errorCount++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/periphTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module periphTop (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 reqValid,
    input  periphPkg::periphReq req,
    output logic                reqReady,
    output logic                rspValid,
    output periphPkg::periphRsp rsp,
    input  wire                 rspReady,
    output logic [63:0]         mtime,
    output logic [63:0]         mtimecmp,
    output logic                timerIrq,
    output logic                reboot,
    output logic                powerOff
);

    import periphPkg::*;

    logic        rspFree;
    logic        issue;
    periphStaged issued;
    logic        timerHit;
    logic        sysHit;
    logic [31:0] timerRdata;

    periphReqIn periphReqIn_i (
        .clk      (clk),
        .rst      (rst),
        .reqValid (reqValid),
        .req      (req),
        .reqReady (reqReady),
        .rspFree  (rspFree),
        .issue    (issue),
        .issued   (issued),
        .timerHit (timerHit),
        .sysHit   (sysHit)
    );

    aclintTimer aclintTimer_i (
        .clk        (clk),
        .rst        (rst),
        .timerHit   (timerHit),
        .issued     (issued),
        .timerRdata (timerRdata),
        .mtime      (mtime),
        .mtimecmp   (mtimecmp),
        .timerIrq   (timerIrq)
    );

    sysCtrl sysCtrl_i (
        .clk      (clk),
        .rst      (rst),
        .sysHit   (sysHit),
        .issued   (issued),
        .reboot   (reboot),
        .powerOff (powerOff)
    );

    periphRspOut periphRspOut_i (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .issued     (issued),
        .timerRdata (timerRdata),
        .rspFree    (rspFree),
        .rspValid   (rspValid),
        .rsp        (rsp),
        .rspReady   (rspReady)
    );

endmodule

`default_nettype wire

// ==== src/periphRspOut.sv ====
`timescale 1ns/10ps
`default_nettype none

module periphRspOut (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    issue,
    input  periphPkg::periphStaged issued,
    input  wire [31:0]             timerRdata,
    output logic                   rspFree,
    output logic                   rspValid,
    output periphPkg::periphRsp    rsp,
    input  wire                    rspReady
);

    import periphPkg::*;

    periphRsp rspNext;
    periphRsp rspHold;

    // Writes and syscon reads return zero.
    always_comb begin
        rspNext.err = (issued.target == TGT_NONE);
        if (!issued.req.write && issued.target == TGT_TIMER) begin
            rspNext.rdata = timerRdata;
        end else begin
            rspNext.rdata = 32'd0;
        end
    end

    // Room when empty or draining this cycle.
    assign rspFree = !rspValid || rspReady;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rspValid <= 1'b0;
        end else if (issue) begin
            rspValid <= 1'b1;
        end else if (rspReady) begin
            rspValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            rspHold <= rspNext;
        end
    end

    assign rsp = rspHold;

endmodule

`default_nettype wire

// ==== src/sysCtrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module sysCtrl (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    sysHit,
    input  periphPkg::periphStaged issued,
    output logic                   reboot,
    output logic                   powerOff
);

    import periphPkg::*;

    logic       cmdWrite;
    logic [7:0] cmdByte;

    // Only byte 0 carries a command.
    assign cmdWrite = sysHit && issued.req.write && issued.req.wmask[0];
    assign cmdByte  = issued.req.wdata[7:0];

    // Pulses last one cycle.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reboot   <= 1'b0;
            powerOff <= 1'b0;
        end else begin
            reboot   <= cmdWrite && (cmdByte == REBOOT_CODE);
            powerOff <= cmdWrite && (cmdByte == POWEROFF_CODE);
        end
    end

endmodule

`default_nettype wire

// ==== src/aclintTimer.sv ====
`timescale 1ns/10ps
`default_nettype none

module aclintTimer (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    timerHit,
    input  periphPkg::periphStaged issued,
    output logic [31:0]            timerRdata,
    output logic [63:0]            mtime,
    output logic [63:0]            mtimecmp,
    output logic                   timerIrq
);

    import periphPkg::*;

    logic [63:0] mtimeNext;
    logic [63:0] mtimecmpNext;
    logic        timerWrite;

    // Replace only the enabled bytes of a word.
    function automatic logic [31:0] mergeBytes(
        input logic [31:0] oldWord,
        input logic [31:0] newWord,
        input logic [3:0]  mask
    );
        logic [31:0] result;
        result = oldWord;
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                result[8*i +: 8] = newWord[8*i +: 8];
            end
        end
        return result;
    endfunction

    assign timerWrite = timerHit && issued.req.write;

    // Masked bytes of an mtime write win over the increment.
    always_comb begin
        mtimeNext    = mtime + 64'd1;
        mtimecmpNext = mtimecmp;
        if (timerWrite) begin
            case (issued.req.wordAddr)
                MTIME_LO_WORD: begin
                    mtimeNext[31:0] = mergeBytes(mtimeNext[31:0], issued.req.wdata,
                                                 issued.req.wmask);
                end
                MTIME_HI_WORD: begin
                    mtimeNext[63:32] = mergeBytes(mtimeNext[63:32], issued.req.wdata,
                                                  issued.req.wmask);
                end
                MTIMECMP_LO_WORD: begin
                    mtimecmpNext[31:0] = mergeBytes(mtimecmp[31:0], issued.req.wdata,
                                                    issued.req.wmask);
                end
                MTIMECMP_HI_WORD: begin
                    mtimecmpNext[63:32] = mergeBytes(mtimecmp[63:32], issued.req.wdata,
                                                     issued.req.wmask);
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtime    <= 64'd0;
            mtimecmp <= '1;
            timerIrq <= 1'b0;
        end else begin
            mtime    <= mtimeNext;
            mtimecmp <= mtimecmpNext;
            timerIrq <= (mtime >= mtimecmp);
        end
    end

    // Read word from the current register values.
    always_comb begin
        case (issued.req.wordAddr)
            MTIME_LO_WORD:    timerRdata = mtime[31:0];
            MTIME_HI_WORD:    timerRdata = mtime[63:32];
            MTIMECMP_LO_WORD: timerRdata = mtimecmp[31:0];
            MTIMECMP_HI_WORD: timerRdata = mtimecmp[63:32];
            default:          timerRdata = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/periphReqIn.sv ====
`timescale 1ns/10ps
`default_nettype none

module periphReqIn (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    reqValid,
    input  periphPkg::periphReq    req,
    output logic                   reqReady,
    input  wire                    rspFree,
    output logic                   issue,
    output periphPkg::periphStaged issued,
    output logic                   timerHit,
    output logic                   sysHit
);

    import periphPkg::*;

    logic        stageFull;
    logic        accept;
    periphTarget reqTarget;
    periphStaged stage;

    // Address decode of the incoming request.
    always_comb begin
        case (req.wordAddr)
            MTIME_LO_WORD,
            MTIME_HI_WORD,
            MTIMECMP_LO_WORD,
            MTIMECMP_HI_WORD: reqTarget = TGT_TIMER;
            SYSCON_WORD:      reqTarget = TGT_SYSCON;
            default:          reqTarget = TGT_NONE;
        endcase
    end

    // Issue once the response register has room.
    assign issue    = stageFull && rspFree;
    assign reqReady = !stageFull || issue;
    assign accept   = reqValid && reqReady;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stageFull <= 1'b0;
        end else if (accept) begin
            stageFull <= 1'b1;
        end else if (issue) begin
            stageFull <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage.req    <= req;
            stage.target <= reqTarget;
        end
    end

    assign issued = stage;

    // One strobe per mapped target.
    assign timerHit = issue && (stage.target == TGT_TIMER);
    assign sysHit   = issue && (stage.target == TGT_SYSCON);

endmodule

`default_nettype wire

// ==== src/periphPkg.sv ====
`default_nettype none

package periphPkg;

    // Byte addresses of the mapped registers.
    localparam logic [31:0] MTIME_ADDR    = 32'h0200BFF8;
    localparam logic [31:0] MTIMECMP_ADDR = 32'h02004000;
    localparam logic [31:0] SYSCON_ADDR   = 32'hFF000004;

    // Word addresses as seen on the request channel.
    localparam logic [29:0] MTIME_LO_WORD    = MTIME_ADDR[31:2];
    localparam logic [29:0] MTIME_HI_WORD    = MTIME_ADDR[31:2] + 30'd1;
    localparam logic [29:0] MTIMECMP_LO_WORD = MTIMECMP_ADDR[31:2];
    localparam logic [29:0] MTIMECMP_HI_WORD = MTIMECMP_ADDR[31:2] + 30'd1;
    localparam logic [29:0] SYSCON_WORD      = SYSCON_ADDR[31:2];

    // Magic values for the system controller.
    localparam logic [7:0] REBOOT_CODE   = 8'h77;
    localparam logic [7:0] POWEROFF_CODE = 8'h55;

    typedef struct packed {
        logic        write;
        logic [29:0] wordAddr;
        logic [3:0]  wmask;
        logic [31:0] wdata;
    } periphReq;

    typedef enum logic [1:0] {
        TGT_NONE   = 2'd0,
        TGT_TIMER  = 2'd1,
        TGT_SYSCON = 2'd2
    } periphTarget;

    typedef struct packed {
        periphReq    req;
        periphTarget target;
    } periphStaged;

    // err flags an access to an unmapped address.
    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } periphRsp;

endpackage

`default_nettype wire
